// File: arb_mux_settings.svh
// build-time settings for the arbitrated request concentrator
// requester count and payload field widths
`ifndef ARB_MUX_SETTINGS_SVH
`define ARB_MUX_SETTINGS_SVH

// number of requesters on the concentrator, at least 2
`define ARB_NUM_REQS 4

// payload field widths
`define ARB_ADDR_W 12
`define ARB_DATA_W 16

`endif

// File: arb_types_pkg.sv
// arbitration types shared by the arbiter, the grant bus and the mux
// request/grant/priority vector and binary port number
`include "arb_mux_settings.svh"

package arb_types_pkg;

  // requester count, taken once from the settings header
  localparam int arb_num_reqs = `ARB_NUM_REQS;

  // width of a binary requester index
  localparam int arb_id_w = $clog2(`ARB_NUM_REQS);

  // --------------------------------------------------
  // one bit per requester
  // used for requests, one-hot grants and one-hot priority
  typedef logic [arb_num_reqs-1:0] req_vec_t;

  // binary requester number
  typedef logic [arb_id_w-1:0] port_id_t;

endpackage

// File: arb_payload_pkg.sv
// payload types carried from requesters to the concentrator output
// opcode enum and the request struct
`include "arb_mux_settings.svh"

package arb_payload_pkg;

  // --------------------------------------------------
  // request opcode, 2 bits
  typedef enum logic [1:0] {
    RD  = 2'b00,
    WR  = 2'b01,
    NOP = 2'b10
  } opcode_t;

  // --------------------------------------------------
  // one request as held by a requester
  // opcode sits in the top bits of the packed word
  typedef struct packed {
    opcode_t                 opcode;
    logic [`ARB_ADDR_W-1:0]  addr;
    logic [`ARB_DATA_W-1:0]  data;
  } req_payload_t;

endpackage

// File: grant_if.sv
// grant bus between the round-robin arbiter and the payload mux
// request levels, one-hot grant, grant valid and binary grant index
interface grant_if;
  import arb_types_pkg::*;

  // request levels, driven by the top level
  req_vec_t reqs;
  // one-hot or zero, combinational in the request cycle
  req_vec_t grants;
  // or of grants
  logic     grant_valid;
  // binary index of the granted requester
  port_id_t grant_id;

  // arbiter side produces the grant
  modport arb (
    input  reqs,
    output grants,
    output grant_valid,
    output grant_id
  );

  // mux side only observes
  modport mux (
    input reqs,
    input grants,
    input grant_valid,
    input grant_id
  );

endinterface

// File: variable_arb_chain.sv
// variable-priority arbiter built from a doubled kill chain
// grants the first request at or after a one-hot priority position
module variable_arb_chain (
  input  logic                    kin,
  input  arb_types_pkg::req_vec_t priority_oh,
  input  arb_types_pkg::req_vec_t reqs,
  output arb_types_pkg::req_vec_t grants,
  output logic                    kout
);
  import arb_types_pkg::*;

  // a circular chain would be a combinational loop, so the chain is
  // laid out twice and the wrap-around happens in the second copy
  logic [2*arb_num_reqs:0]   kills;
  logic [2*arb_num_reqs-1:0] prio_2x;
  logic [2*arb_num_reqs-1:0] reqs_2x;
  logic [2*arb_num_reqs-1:0] grants_2x;

  // everything below the priority position starts out killed
  assign kills[0] = 1'b1;

  // priority marker only in the lower copy
  assign prio_2x = {{arb_num_reqs{1'b0}}, priority_oh};
  assign reqs_2x = {reqs, reqs};

  // --------------------------------------------------
  // per-position grant and kill
  for (genvar i = 0; i < 2*arb_num_reqs; i++) begin : g_stage
    // the priority position ignores the kill from below
    assign grants_2x[i] = prio_2x[i] ? reqs_2x[i] : (!kills[i] && reqs_2x[i]);

    // kill passes on once killed or once this position has won
    assign kills[i+1] = prio_2x[i] ? grants_2x[i] : (kills[i] || grants_2x[i]);
  end

  // --------------------------------------------------
  // fold both copies back onto the requesters
  // only one copy can grant, so the or stays one-hot
  // kin blocks every grant, kin is applied last so the chain
  // resolves without waiting on it
  assign grants = (grants_2x[arb_num_reqs-1:0] | grants_2x[2*arb_num_reqs-1:arb_num_reqs])
                  & {arb_num_reqs{~kin}};

  // a grant was taken somewhere, or the whole chain was killed
  assign kout = kills[2*arb_num_reqs] || kin;

endmodule

// File: round_robin_arb.sv
// round-robin arbiter over the doubled kill chain
// one-hot priority register, rotation on grant, grant index encoder
module round_robin_arb (
  input  logic clock,
  input  logic rstn,
  input  logic hold,
  grant_if.arb gnt
);
  import arb_types_pkg::*;

  // one-hot, marks the requester with highest priority
  req_vec_t priority_oh;
  req_vec_t priority_next;
  port_id_t id_enc;

  // --------------------------------------------------
  // arbitration
  // hold kills the chain so no grant leaves while it is high
  variable_arb_chain u_chain (
    .kin         (hold),
    .priority_oh (priority_oh),
    .reqs        (gnt.reqs),
    .grants      (gnt.grants),
    .kout        ()
  );

  assign gnt.grant_valid = |gnt.grants;

  // --------------------------------------------------
  // priority update
  // winner drops to lowest priority: the slot above it becomes highest
  assign priority_next = {gnt.grants[arb_num_reqs-2:0], gnt.grants[arb_num_reqs-1]};

  // no grant (idle or hold) leaves the priority where it is
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      // requester 0 first after reset
      priority_oh <= req_vec_t'(1);
    end else if (gnt.grant_valid) begin
      priority_oh <= priority_next;
    end
  end

  // --------------------------------------------------
  // one-hot to binary
  // grant is one-hot, so or-ing the indices of set bits is exact
  always_comb begin
    id_enc = '0;
    for (int i = 0; i < arb_num_reqs; i++) begin
      if (gnt.grants[i]) begin
        id_enc = id_enc | port_id_t'(i);
      end
    end
  end

  assign gnt.grant_id = id_enc;

endmodule

// File: payload_mux.sv
// payload multiplexer behind the arbiter
// and-or select under the one-hot grant, output register stage
module payload_mux #(
  parameter type payload_t = logic
) (
  input  logic                    clock,
  input  logic                    rstn,
  grant_if.mux                    gnt,
  input  payload_t                payloads [arb_types_pkg::arb_num_reqs],
  output logic                    out_valid,
  output payload_t                out_payload,
  output arb_types_pkg::port_id_t out_id
);
  import arb_types_pkg::*;

  // grant bits qualified by the live request levels
  req_vec_t sel_mask;
  // selected payload before the register
  payload_t sel_payload;

  assign sel_mask = gnt.grants & gnt.reqs;

  // --------------------------------------------------
  // and-or select
  // one-hot mask means at most one term is non-zero
  always_comb begin
    sel_payload = payload_t'(0);
    for (int i = 0; i < arb_num_reqs; i++) begin
      sel_payload = payload_t'(sel_payload
                    | (payloads[i] & {$bits(payload_t){sel_mask[i]}}));
    end
  end

  // --------------------------------------------------
  // output stage, one cycle after the granting edge
  // valid follows grant_valid every cycle, so a hold or idle cycle
  // shows up as a low out_valid one cycle later
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= gnt.grant_valid;
    end
  end

  // payload and port number load only on a grant
  // between grants they keep the last served item
  always_ff @(posedge clock) begin
    if (gnt.grant_valid) begin
      out_payload <= sel_payload;
      out_id      <= gnt.grant_id;
    end
  end

endmodule

// File: arb_mux_top.sv
// top level of the arbitrated request concentrator
// round-robin arbiter and payload mux joined by the grant bus
module arb_mux_top (
  input  logic                          clock,
  input  logic                          rstn,
  // high blocks all grants and freezes the priority
  input  logic                          hold,
  // request levels, one per requester
  input  arb_types_pkg::req_vec_t       reqs,
  input  arb_payload_pkg::req_payload_t req_payloads [arb_types_pkg::arb_num_reqs],
  // one-hot grant pulse, same cycle as the request
  output arb_types_pkg::req_vec_t       grants,
  // served item, one cycle after its grant
  output logic                          out_valid,
  output arb_payload_pkg::req_payload_t out_payload,
  output arb_types_pkg::port_id_t       out_id
);
  import arb_payload_pkg::*;

  // --------------------------------------------------
  // grant bus
  grant_if gnt_bus ();

  // requesters drive the bus request levels directly
  assign gnt_bus.reqs = reqs;

  // grant goes back to the requesters as a plain vector
  assign grants = gnt_bus.grants;

  // --------------------------------------------------
  // arbiter
  // hold enters the chain as its kill input
  round_robin_arb u_arb (
    .clock (clock),
    .rstn  (rstn),
    .hold  (hold),
    .gnt   (gnt_bus.arb)
  );

  // --------------------------------------------------
  // payload path
  // one instance, carrying the full request struct
  payload_mux #(
    .payload_t (req_payload_t)
  ) u_mux (
    .clock       (clock),
    .rstn        (rstn),
    .gnt         (gnt_bus.mux),
    .payloads    (req_payloads),
    .out_valid   (out_valid),
    .out_payload (out_payload),
    .out_id      (out_id)
  );

endmodule

// File: arb_mux_asserts.sv
// concurrent checks for the arbitrated request concentrator
// one-hot grants, hold blocking, out_valid one cycle behind grant_valid
// bound into round_robin_arb and payload_mux at the end of the file
module arb_mux_asserts #(
  // arbiter side checks hold, mux side checks the output stage
  parameter bit arb_side = 1'b1
) (
  input logic                    clock,
  input logic                    rstn,
  input logic                    hold,
  input arb_types_pkg::req_vec_t grants,
  input logic                    grant_valid,
  input logic                    out_valid
);

  // at most one requester wins per cycle
  a_grant_onehot : assert property (@(posedge clock) disable iff (!rstn)
    $onehot0(grants))
    else $error("grant vector has more than one bit set");

  if (arb_side) begin : g_arb
    // hold acts as the chain kill, nothing may leave
    a_hold_blocks : assert property (@(posedge clock) disable iff (!rstn)
      hold |-> (grants == '0))
      else $error("grant issued while hold is high");
  end else begin : g_mux
    // output register stage is exactly one cycle deep
    a_valid_follows : assert property (@(posedge clock) disable iff (!rstn)
      out_valid == $past(grant_valid))
      else $error("out_valid does not follow grant_valid by one cycle");
  end

endmodule

bind round_robin_arb arb_mux_asserts #(.arb_side(1'b1)) u_asserts (
  .clock       (clock),
  .rstn        (rstn),
  .hold        (hold),
  .grants      (gnt.grants),
  .grant_valid (gnt.grant_valid),
  .out_valid   (1'b0)
);

bind payload_mux arb_mux_asserts #(.arb_side(1'b0)) u_asserts (
  .clock       (clock),
  .rstn        (rstn),
  .hold        (1'b0),
  .grants      (gnt.grants),
  .grant_valid (gnt.grant_valid),
  .out_valid   (out_valid)
);

// File: arb_mux_tb.sv
// testbench for the arbitrated request concentrator
// clock, reset, directed and random stimulus, round-robin reference model
// compare tasks, per-test lines, closing counts and a cycle timeout
module arb_mux_tb;
  import arb_types_pkg::*;
  import arb_payload_pkg::*;

  localparam int clk_period      = 20;
  localparam int drive_delay     = 2;
  localparam int reset_cycles    = 10;
  localparam int seed            = 8053;
  localparam int directed_cycles = 30;
  localparam int random_cycles   = 400;
  // twice the stimulus length plus reset
  localparam int timeout_cycles  = 2 * (directed_cycles + random_cycles) + reset_cycles;

  logic         clock;
  logic         rstn;
  logic         hold;
  req_vec_t     reqs;
  req_payload_t req_payloads [arb_num_reqs];
  req_vec_t     grants;
  logic         out_valid;
  req_payload_t out_payload;
  port_id_t     out_id;

  // reference model state
  int           prio_idx;
  int           winner;
  req_vec_t     exp_grants;
  logic         exp_valid;
  req_payload_t exp_payload;
  port_id_t     exp_id;

  // bookkeeping
  int           checks;
  int           errors;
  int           test_num;
  int           test_base;
  int           cycle_count;
  req_payload_t saved_payload;

  arb_mux_top u_dut (
    .clock        (clock),
    .rstn         (rstn),
    .hold         (hold),
    .reqs         (reqs),
    .req_payloads (req_payloads),
    .grants       (grants),
    .out_valid    (out_valid),
    .out_payload  (out_payload),
    .out_id       (out_id)
  );

  always #(clk_period / 2) clock = ~clock;

  // --------------------------------------------------
  // reference model and helpers

  // first requester at or after prio with wrap-around
  // -1 when nothing requests or hold is high
  function automatic int ref_winner(input int prio, input req_vec_t r, input logic h);
    int idx;
    if (h) begin
      return -1;
    end
    for (int k = 0; k < arb_num_reqs; k++) begin
      idx = (prio + k) % arb_num_reqs;
      if (r[port_id_t'(idx)]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  function automatic req_vec_t onehot(input int idx);
    return req_vec_t'(1) << idx;
  endfunction

  function automatic req_payload_t rand_payload();
    logic [63:0]  rnd;
    req_payload_t p;
    rnd = {$urandom, $urandom};
    p = rnd[$bits(req_payload_t)-1:0];
    // only RD, WR and NOP are legal
    p.opcode = opcode_t'(rnd[63:62] % 2'd3);
    return p;
  endfunction

  task automatic check_grants(input req_vec_t got, input req_vec_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s grants %b, expected %b", $time, what, got, exp);
    end
  endtask

  // payload and port are only meaningful when valid is expected
  task automatic check_output(input logic got_v, input req_payload_t got_p,
                              input port_id_t got_id, input logic exp_v,
                              input req_payload_t exp_p, input port_id_t exp_i,
                              input string what);
    checks++;
    if (got_v !== exp_v) begin
      errors++;
      $display("ERROR %0t: %s out_valid %b, expected %b", $time, what, got_v, exp_v);
    end else if (exp_v && (got_p !== exp_p || got_id !== exp_i)) begin
      errors++;
      $display("ERROR %0t: %s output %h port %0d, expected %h port %0d",
               $time, what, got_p, got_id, exp_p, exp_i);
    end
  endtask

  // new inputs a short delay after the rising edge
  task automatic drive_cycle(input logic h, input req_vec_t r);
    @(posedge clock);
    #(drive_delay);
    hold = h;
    reqs = r;
    for (int i = 0; i < arb_num_reqs; i++) begin
      req_payloads[i] = rand_payload();
    end
  endtask

  // sample just before the next rising edge
  task automatic wait_sample();
    #(clk_period - drive_delay - 1);
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("test %0d %s: done, %0d errors", test_num, name, errors - test_base);
    test_base = errors;
  endtask

  // --------------------------------------------------
  // compare process checks the DUT against the model every cycle
  // it samples one unit ahead of the directed checks
  always begin
    @(posedge clock);
    #(clk_period - 2);
    if (!rstn) begin
      prio_idx  = 0;
      exp_valid = 1'b0;
    end else begin
      check_output(out_valid, out_payload, out_id, exp_valid, exp_payload, exp_id, "model");
      winner = ref_winner(prio_idx, reqs, hold);
      exp_grants = (winner < 0) ? '0 : onehot(winner);
      check_grants(grants, exp_grants, "model");
      exp_valid = (winner >= 0);
      if (winner >= 0) begin
        exp_id      = port_id_t'(winner);
        exp_payload = req_payloads[exp_id];
        // winner drops to lowest priority
        prio_idx    = (winner + 1) % arb_num_reqs;
      end
    end
  end

  // run limit
  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("run timed out after %0d cycles without finishing", cycle_count);
      $display("tests failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // stimulus
  initial begin
    clock = 1'b0;
    rstn  = 1'b0;
    hold  = 1'b0;
    reqs  = '0;
    for (int i = 0; i < arb_num_reqs; i++) begin
      req_payloads[i] = '0;
    end
    checks      = 0;
    errors      = 0;
    test_num    = 0;
    test_base   = 0;
    cycle_count = 0;
    void'($urandom(seed));
    repeat (reset_cycles) @(posedge clock);
    #(drive_delay);
    rstn = 1'b1;

    // lone requester 2 straight after reset
    drive_cycle(1'b0, '0);
    wait_sample();
    check_grants(grants, '0, "idle after reset");
    check_output(out_valid, out_payload, out_id, 1'b0, '0, '0, "idle after reset");
    drive_cycle(1'b0, onehot(2));
    wait_sample();
    check_grants(grants, onehot(2), "lone request");
    saved_payload = req_payloads[2];
    drive_cycle(1'b0, '0);
    wait_sample();
    check_output(out_valid, out_payload, out_id, 1'b1, saved_payload, 2, "lone request");
    end_test("lone requester");

    // a lone grant to requester 3 moves the priority to 0 for the full rotation
    drive_cycle(1'b0, onehot(3));
    for (int k = 0; k < 5; k++) begin
      drive_cycle(1'b0, '1);
      wait_sample();
      check_grants(grants, onehot(k % arb_num_reqs), "full rotation");
    end
    end_test("all requesting");

    // only 1 and 3 request so idle ports get skipped
    for (int k = 0; k < 6; k++) begin
      drive_cycle(1'b0, onehot(1) | onehot(3));
      wait_sample();
      check_grants(grants, (k % 2 == 0) ? onehot(1) : onehot(3), "sparse rotation");
    end
    end_test("alternating 1 and 3");

    // a grant to 1 leaves the priority at 2 for hold to keep
    drive_cycle(1'b0, onehot(1));
    for (int k = 0; k < 4; k++) begin
      drive_cycle(1'b1, '1);
      wait_sample();
      check_grants(grants, '0, "hold");
      if (k > 0) begin
        check_output(out_valid, out_payload, out_id, 1'b0, '0, '0, "hold");
      end
    end
    drive_cycle(1'b0, '1);
    wait_sample();
    check_grants(grants, onehot(2), "after hold");
    end_test("hold");

    // random requests and payloads with about one hold cycle in 16
    for (int n = 0; n < random_cycles; n++) begin
      drive_cycle(($urandom % 16) == 0, req_vec_t'($urandom));
    end
    drive_cycle(1'b0, '0);
    drive_cycle(1'b0, '0);
    end_test("random");

    @(posedge clock);
    #(drive_delay);
    $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: arb_mux.f
+incdir+.
arb_types_pkg.sv
arb_payload_pkg.sv
grant_if.sv
variable_arb_chain.sv
round_robin_arb.sv
payload_mux.sv
arb_mux_top.sv
arb_mux_asserts.sv
arb_mux_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the arb_mux testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module arb_mux_tb -f arb_mux.f -o arb_mux_sim

# a simulator stop still leaves its output for the search below
sim_out=$(./obj_dir/arb_mux_sim) || true
echo "$sim_out"

if grep -qx "all tests passed" <<< "$sim_out"; then
  exit 0
fi
exit 1
